// ==== sim.f ====
+incdir+tb
source/pst_cfg_pkg.sv
source/pst_types_pkg.sv
source/vreg_create_capture.sv
source/vreg_retire_match.sv
source/vreg_status_fsm.sv
source/vreg_release_decode.sv
source/pst_vreg_entry.sv
tb/tb_pst_vreg_entry.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the status entry testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
  --top-module tb_pst_vreg_entry -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_pst_vreg_entry 2>&1)
sim_status=$?
echo "$out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// ==== tb/pst_entry_model.svh ====
// Reference model of one status entry, advanced once per rising sm_clk edge
// Included inside the testbench module; needs dis_slots, ret_slots and both packages
`ifndef pst_entry_model_svh
`define pst_entry_model_svh

// Expected registered state of the entry
typedef struct packed {
  lifecycle_e           life;
  wb_e                  wb;
  entry_info_t          info;
  logic [ret_slots-1:0] match;
} model_state_t;

typedef struct packed {
  logic [num_vreg-1:0] rel;
  logic [num_areg-1:0] dreg;
  entry_status_t       status;
} model_out_t;

function automatic model_state_t model_reset();
  model_state_t r;
  r      = '0;
  r.life = st_dealloc;
  r.wb   = wb_idle;
  return r;
endfunction

// Next state; create_sel is one-hot or zero
function automatic model_state_t model_next(
  input model_state_t                    m,
  input sys_event_t                      s,
  input entry_cmd_t                      c,
  input logic [dis_slots-1:0]            sel,
  input entry_info_t [dis_slots-1:0]     dis,
  input logic [dstv_w-1:0]               rst_dstv,
  input retire_preview_t [ret_slots-1:0] pv,
  input logic [ret_slots-1:0]            commit
);
  model_state_t n;
  logic         create;
  logic         retire;
  logic         wb_ok;
  n      = m;
  create = |sel;
  retire = |(m.match & commit);
  wb_ok  = (m.wb == wb_done) && !c.dealloc_mask;

  if (s.sync_reset) begin
    n.info          = '0;
    n.info.dstv_reg = rst_dstv;
  end else begin
    for (int k = 0; k < dis_slots; k++) begin
      if (sel[k]) n.info = dis[k];
    end
  end

  for (int k = 0; k < ret_slots; k++) begin
    if (s.sync_reset) begin
      n.match[k] = 1'b0;
    end else if (pv[k].vld) begin
      n.match[k] = (m.life == st_alloc) && (pv[k].iid == m.info.iid);
    end
  end

  if (s.sync_reset) begin
    n.life = s.reset_mapped ? st_retire : st_dealloc;
  end else begin
    case (m.life)
      st_dealloc:  if (c.dealloc_vld && !s.flush) n.life = st_wf_alloc;
      st_wf_alloc: begin
        if (s.flush) n.life = st_dealloc;
        else if (create) n.life = st_alloc;
      end
      st_alloc: begin
        if (s.flush) n.life = st_dealloc;
        else if (c.release_vld) n.life = wb_ok ? st_dealloc : st_release;
        else if (retire) n.life = st_retire;
      end
      st_retire:   if (c.release_vld) n.life = wb_ok ? st_dealloc : st_release;
      st_release:  if (wb_ok) n.life = st_dealloc;
      default:     n.life = st_dealloc;
    endcase
  end

  // Write-back flag in priority order
  if (s.async_flush) n.wb = wb_done;
  else if (s.sync_reset) n.wb = s.reset_mapped ? wb_done : wb_idle;
  else if (create) n.wb = wb_idle;
  else if ((m.wb == wb_idle) && c.wb_vld) n.wb = wb_done;
  else if ((m.wb == wb_done) && (m.life == st_dealloc)) n.wb = wb_idle;
  return n;
endfunction

// Expected outputs from model state and the current commit
function automatic model_out_t model_outputs(
  input model_state_t         m,
  input logic [ret_slots-1:0] commit
);
  model_out_t o;
  logic       retiring;
  o        = '0;
  retiring = (m.life == st_alloc) && |(m.match & commit);
  if (retiring) o.rel[m.info.rel_vreg] = 1'b1;
  if (m.life == st_retire) o.dreg[m.info.dstv_reg] = 1'b1;
  o.status.is_dealloc       = (m.life == st_dealloc);
  o.status.alloc_or_release = (m.life == st_alloc) || (m.life == st_release);
  if (retiring || (m.life == st_retire) || (m.life == st_release)) begin
    o.status.retired_released_wb = (m.wb == wb_done);
  end else begin
    o.status.retired_released_wb = 1'b1;
  end
  return o;
endfunction

`endif

// ==== tb/tb_pst_vreg_entry.sv ====
// Testbench for pst_vreg_entry; a reference model predicts every output each cycle
// Inputs change on the falling edge, outputs are compared 5 ns before it
`default_nettype none
`timescale 1ns/1ps

module tb_pst_vreg_entry;

  import pst_cfg_pkg::*;
  import pst_types_pkg::*;

  localparam int dis_slots = dis_slots_default;
  localparam int ret_slots = ret_slots_default;

  logic                            sm_clk;
  logic                            cpurst_b;
  sys_event_t                      sys;
  entry_cmd_t                      cmd;
  entry_info_t [dis_slots-1:0]     dis_inst;
  logic [dis_slots-1:0]            create_sel;
  logic [dstv_w-1:0]               reset_dstv_reg;
  retire_preview_t [ret_slots-1:0] ret_preview;
  logic [ret_slots-1:0]            ret_commit;
  logic [num_vreg-1:0]             rel_vreg_onehot;
  logic [num_areg-1:0]             dreg_onehot;
  entry_status_t                   status;

  `include "pst_entry_model.svh"

  model_state_t mdl;
  model_out_t   exp_out;

  pst_vreg_entry #(.dis_slots(dis_slots), .ret_slots(ret_slots)) dut (
    .sm_clk          (sm_clk),
    .cpurst_b        (cpurst_b),
    .sys             (sys),
    .cmd             (cmd),
    .dis_inst        (dis_inst),
    .create_sel      (create_sel),
    .reset_dstv_reg  (reset_dstv_reg),
    .ret_preview     (ret_preview),
    .ret_commit      (ret_commit),
    .rel_vreg_onehot (rel_vreg_onehot),
    .dreg_onehot     (dreg_onehot),
    .status          (status)
  );

  initial sm_clk = 1'b0;
  always #20 sm_clk = ~sm_clk;

  // ====================
  // Model and compare
  // ====================

  always @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      mdl <= model_reset();
    end else begin
      mdl <= model_next(mdl, sys, cmd, create_sel, dis_inst, reset_dstv_reg,
                        ret_preview, ret_commit);
    end
  end

  always begin
    @(posedge sm_clk);
    #15;
    if (cpurst_b) begin
      exp_out = model_outputs(mdl, ret_commit);
      check_status(status, exp_out.status);
      check_rel(rel_vreg_onehot, exp_out.rel);
      check_dreg(dreg_onehot, exp_out.dreg);
    end
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_status(input entry_status_t got, input entry_status_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Error: status = %h, expected %h at %0t", got, exp, $time));
    end
  endtask

  task automatic check_rel(input logic [num_vreg-1:0] got, input logic [num_vreg-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Error: rel_vreg_onehot = %h, expected %h at %0t",
                                  got, exp, $time));
    end
  endtask

  task automatic check_dreg(input logic [num_areg-1:0] got, input logic [num_areg-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Error: dreg_onehot = %h, expected %h at %0t",
                                  got, exp, $time));
    end
  endtask

  function automatic entry_status_t status_of(input logic d, input logic a, input logic w);
    entry_status_t s;
    s.is_dealloc          = d;
    s.alloc_or_release    = a;
    s.retired_released_wb = w;
    return s;
  endfunction

  function automatic logic [num_vreg-1:0] onehot_vreg(input logic [vreg_w-1:0] idx);
    logic [num_vreg-1:0] v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  function automatic logic [num_areg-1:0] onehot_areg(input logic [dstv_w-1:0] idx);
    logic [num_areg-1:0] v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  function automatic entry_info_t random_info();
    entry_info_t i;
    i.iid      = iid_w'($urandom);
    i.dstv_reg = dstv_w'($urandom);
    i.rel_vreg = vreg_w'($urandom);
    return i;
  endfunction

  // ====================
  // Stimulus helpers
  // ====================

  task automatic clear_inputs();
    sys            = '0;
    cmd            = '0;
    dis_inst       = '0;
    create_sel     = '0;
    reset_dstv_reg = '0;
    ret_preview    = '0;
    ret_commit     = '0;
  endtask

  // Hold the current drive for one cycle
  task automatic pulse_cycle();
    @(negedge sm_clk);
    clear_inputs();
  endtask

  // Status bits and dreg_onehot depend on registered state only
  function automatic logic state_seen(input lifecycle_e target);
    case (target)
      st_dealloc:  return status.is_dealloc;
      st_wf_alloc: return !status.is_dealloc && !status.alloc_or_release && (dreg_onehot == '0);
      st_retire:   return dreg_onehot != '0;
      default:     return status.alloc_or_release;
    endcase
  endfunction

  task automatic wait_for_state(input lifecycle_e target);
    int waited;
    waited = 0;
    while (!state_seen(target)) begin
      if (waited == 200) begin
        stop_with_failure($sformatf("Timed out after 200 cycles waiting for state %s",
                                    target.name()));
      end else begin
        @(negedge sm_clk);
        waited++;
      end
    end
  endtask

  task automatic to_alloc(input int slot, output entry_info_t made);
    cmd.dealloc_vld = 1'b1;
    pulse_cycle();
    wait_for_state(st_wf_alloc);
    for (int k = 0; k < dis_slots; k++) begin
      dis_inst[k] = random_info();
    end
    made             = dis_inst[slot];
    create_sel[slot] = 1'b1;
    pulse_cycle();
    wait_for_state(st_alloc);
  endtask

  // Preview then commit; previous mapping is freed in the commit cycle
  task automatic retire_entry(input int pslot, input entry_info_t made);
    ret_preview[pslot].vld = 1'b1;
    ret_preview[pslot].iid = made.iid;
    pulse_cycle();
    ret_commit[pslot] = 1'b1;
    #10;
    check_rel(rel_vreg_onehot, onehot_vreg(made.rel_vreg));
    pulse_cycle();
    wait_for_state(st_retire);
    check_dreg(dreg_onehot, onehot_areg(made.dstv_reg));
  endtask

  task automatic release_entry();
    cmd.wb_vld = 1'b1;
    pulse_cycle();
    cmd.release_vld = 1'b1;
    pulse_cycle();
    wait_for_state(st_dealloc);
  endtask

  task automatic random_run(input int cycles);
    int slot;
    for (int c = 0; c < cycles; c++) begin
      @(negedge sm_clk);
      clear_inputs();
      sys.flush        = ($urandom % 16) == 0;
      sys.async_flush  = ($urandom % 32) == 0;
      sys.sync_reset   = ($urandom % 32) == 0;
      sys.reset_mapped = ($urandom % 2) == 1;
      cmd.dealloc_vld  = ($urandom % 4) == 0;
      cmd.dealloc_mask = ($urandom % 4) == 0;
      cmd.release_vld  = ($urandom % 8) == 0;
      cmd.wb_vld       = ($urandom % 4) == 0;
      reset_dstv_reg   = dstv_w'($urandom);
      // Small IID range so previews hit often
      for (int k = 0; k < dis_slots; k++) begin
        dis_inst[k]     = random_info();
        dis_inst[k].iid = iid_w'($urandom % 4);
      end
      if (($urandom % 4) == 0) begin
        slot             = $urandom % dis_slots;
        create_sel[slot] = 1'b1;
      end
      for (int k = 0; k < ret_slots; k++) begin
        ret_preview[k].vld = ($urandom % 2) == 1;
        ret_preview[k].iid = iid_w'($urandom % 4);
      end
      ret_commit = ret_slots'($urandom);
    end
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    entry_info_t made;
    void'($urandom(32'ha132f2cb));
    cpurst_b = 1'b0;
    clear_inputs();
    repeat (4) @(negedge sm_clk);
    cpurst_b = 1'b1;
    #10;
    check_status(status, status_of(1'b1, 1'b0, 1'b1));
    check_rel(rel_vreg_onehot, '0);
    check_dreg(dreg_onehot, '0);
    @(negedge sm_clk);

    // Full lifecycle from every dispatch slot
    for (int slot = 0; slot < dis_slots; slot++) begin
      to_alloc(slot, made);
      retire_entry(slot % ret_slots, made);
      release_entry();
    end

    // No retire without a matching preview; sync reset clears old matches
    sys.sync_reset = 1'b1;
    pulse_cycle();
    wait_for_state(st_dealloc);
    to_alloc(0, made);
    ret_commit = '1;
    #10;
    check_rel(rel_vreg_onehot, '0);
    pulse_cycle();
    ret_preview[0].vld = 1'b1;
    ret_preview[0].iid = made.iid ^ iid_w'(1);
    pulse_cycle();
    ret_commit[0] = 1'b1;
    #10;
    check_rel(rel_vreg_onehot, '0);
    pulse_cycle();
    #10;
    check_status(status, status_of(1'b0, 1'b1, 1'b1));
    @(negedge sm_clk);
    release_entry();

    // Flush out of wf_alloc and alloc
    cmd.dealloc_vld = 1'b1;
    pulse_cycle();
    wait_for_state(st_wf_alloc);
    sys.flush = 1'b1;
    pulse_cycle();
    wait_for_state(st_dealloc);
    to_alloc(1, made);
    sys.flush = 1'b1;
    pulse_cycle();
    wait_for_state(st_dealloc);

    // Mask holds a written back entry in release
    to_alloc(2 % dis_slots, made);
    cmd.release_vld = 1'b1;
    pulse_cycle();
    wait_for_state(st_release);
    cmd.wb_vld       = 1'b1;
    cmd.dealloc_mask = 1'b1;
    @(negedge sm_clk);
    cmd.wb_vld = 1'b0;
    repeat (3) begin
      #10;
      check_status(status, status_of(1'b0, 1'b1, 1'b1));
      @(negedge sm_clk);
    end
    clear_inputs();
    wait_for_state(st_dealloc);

    // Sync reset to a mapped entry lands in retire with dstv loaded
    sys.sync_reset   = 1'b1;
    sys.reset_mapped = 1'b1;
    reset_dstv_reg   = dstv_w'($urandom);
    made.dstv_reg    = reset_dstv_reg;
    pulse_cycle();
    wait_for_state(st_retire);
    check_dreg(dreg_onehot, onehot_areg(made.dstv_reg));
    #10;
    check_status(status, status_of(1'b0, 1'b0, 1'b1));
    @(negedge sm_clk);
    cmd.release_vld = 1'b1;
    pulse_cycle();
    wait_for_state(st_dealloc);

    // Unmapped sync reset from alloc
    to_alloc(0, made);
    sys.sync_reset = 1'b1;
    pulse_cycle();
    wait_for_state(st_dealloc);
    #10;
    check_status(status, status_of(1'b1, 1'b0, 1'b1));
    @(negedge sm_clk);

    // Async flush sets the write-back flag of a retired entry
    to_alloc(1, made);
    retire_entry(2 % ret_slots, made);
    #10;
    check_status(status, status_of(1'b0, 1'b0, 1'b0));
    @(negedge sm_clk);
    sys.async_flush = 1'b1;
    pulse_cycle();
    #10;
    check_status(status, status_of(1'b0, 1'b0, 1'b1));
    @(negedge sm_clk);
    cmd.release_vld = 1'b1;
    pulse_cycle();
    wait_for_state(st_dealloc);

    random_run(3000);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/pst_vreg_entry.sv ====
// One entry of the vector physical register status table
// Single clock sm_clk; every strobe is valid for exactly one cycle
`default_nettype none
`timescale 1ns/1ps

module pst_vreg_entry #(
  parameter int dis_slots = pst_cfg_pkg::dis_slots_default,
  parameter int ret_slots = pst_cfg_pkg::ret_slots_default
) (
  input  wire logic                                       sm_clk,
  input  wire logic                                       cpurst_b,
  input  pst_types_pkg::sys_event_t                       sys,
  input  pst_types_pkg::entry_cmd_t                       cmd,
  input  pst_types_pkg::entry_info_t [dis_slots-1:0]      dis_inst,
  input  wire logic [dis_slots-1:0]                       create_sel,
  input  wire logic [pst_cfg_pkg::dstv_w-1:0]             reset_dstv_reg,
  input  pst_types_pkg::retire_preview_t [ret_slots-1:0]  ret_preview,
  input  wire logic [ret_slots-1:0]                       ret_commit,
  output logic [pst_cfg_pkg::num_vreg-1:0]                rel_vreg_onehot,
  output logic [pst_cfg_pkg::num_areg-1:0]                dreg_onehot,
  output pst_types_pkg::entry_status_t                    status
);

  import pst_types_pkg::*;

  entry_info_t info;
  lifecycle_e  life_state;
  wb_e         wb_state;
  logic        create_vld;
  logic        retire_vld;
  logic        in_alloc;

  assign in_alloc = (life_state == st_alloc);

  vreg_create_capture #(.dis_slots(dis_slots)) u_create (
    .sm_clk         (sm_clk),
    .cpurst_b       (cpurst_b),
    .dis_inst       (dis_inst),
    .create_sel     (create_sel),
    .sys            (sys),
    .reset_dstv_reg (reset_dstv_reg),
    .create_vld     (create_vld),
    .info           (info)
  );

  vreg_retire_match #(.ret_slots(ret_slots)) u_retire (
    .sm_clk      (sm_clk),
    .cpurst_b    (cpurst_b),
    .ret_preview (ret_preview),
    .ret_commit  (ret_commit),
    .entry_iid   (info.iid),
    .in_alloc    (in_alloc),
    .sys         (sys),
    .retire_vld  (retire_vld)
  );

  vreg_status_fsm u_fsm (
    .sm_clk     (sm_clk),
    .cpurst_b   (cpurst_b),
    .sys        (sys),
    .cmd        (cmd),
    .create_vld (create_vld),
    .retire_vld (retire_vld),
    .life_state (life_state),
    .wb_state   (wb_state)
  );

  vreg_release_decode u_decode (
    .life_state      (life_state),
    .wb_state        (wb_state),
    .retire_vld      (retire_vld),
    .info            (info),
    .rel_vreg_onehot (rel_vreg_onehot),
    .dreg_onehot     (dreg_onehot),
    .status          (status)
  );

endmodule

`default_nettype wire

// ==== source/vreg_release_decode.sv ====
// Purely combinational; outputs follow retire_vld in the same cycle
`default_nettype none
`timescale 1ns/1ps

module vreg_release_decode (
  input  pst_types_pkg::lifecycle_e             life_state,
  input  pst_types_pkg::wb_e                    wb_state,
  input  wire logic                             retire_vld,
  input  pst_types_pkg::entry_info_t            info,
  output logic [pst_cfg_pkg::num_vreg-1:0]      rel_vreg_onehot,
  output logic [pst_cfg_pkg::num_areg-1:0]      dreg_onehot,
  output pst_types_pkg::entry_status_t          status
);

  import pst_cfg_pkg::*;
  import pst_types_pkg::*;

  logic [num_vreg-1:0] rel_expand;
  logic [num_areg-1:0] dreg_expand;
  logic                in_alloc;
  logic                in_retire;
  logic                in_release;
  logic                rel_retire_vld;

  assign in_alloc   = (life_state == st_alloc);
  assign in_retire  = (life_state == st_retire);
  assign in_release = (life_state == st_release);

  // Retiring in this very cycle
  assign rel_retire_vld = in_alloc && retire_vld;

  // ====================
  // Release vector
  // ====================

  // Previous mapping is freed when its successor retires
  assign rel_expand      = num_vreg'(1) << info.rel_vreg;
  assign rel_vreg_onehot = rel_retire_vld ? rel_expand : '0;

  // ====================
  // Recovery vector
  // ====================

  assign dreg_expand = num_areg'(1) << info.dstv_reg;
  assign dreg_onehot = in_retire ? dreg_expand : '0;

  // ====================
  // Status
  // ====================

  assign status.is_dealloc       = (life_state == st_dealloc);
  assign status.alloc_or_release = in_alloc || in_release;

  // Entries not yet retired report as written back
  assign status.retired_released_wb = (rel_retire_vld || in_retire || in_release)
                                      ? (wb_state == wb_done) : 1'b1;

endmodule

`default_nettype wire

// ==== source/vreg_status_fsm.sv ====
// Lifecycle and write-back machines are coupled through dealloc and the masked wb
// Lifecycle ignores async_flush; only the wb flag reacts to it
`default_nettype none
`timescale 1ns/1ps

module vreg_status_fsm (
  input  wire logic                 sm_clk,
  input  wire logic                 cpurst_b,
  input  pst_types_pkg::sys_event_t sys,
  input  pst_types_pkg::entry_cmd_t cmd,
  input  wire logic                 create_vld,
  input  wire logic                 retire_vld,
  output pst_types_pkg::lifecycle_e life_state,
  output pst_types_pkg::wb_e        wb_state
);

  import pst_types_pkg::*;

  lifecycle_e life_nxt;
  lifecycle_e life_reset;
  wb_e        wb_nxt;
  wb_e        wb_reset;
  logic       wb_masked;

  // Written back and the allocator does not hold the entry
  assign wb_masked = (wb_state == wb_done) && !cmd.dealloc_mask;

  // ====================
  // Lifecycle
  // ====================

  assign life_reset = sys.reset_mapped ? st_retire : st_dealloc;

  always_comb begin
    life_nxt = life_state;
    case (life_state)
      st_dealloc: begin
        if (cmd.dealloc_vld && !sys.flush) begin
          life_nxt = st_wf_alloc;
        end
      end
      st_wf_alloc: begin
        if (sys.flush) begin
          life_nxt = st_dealloc;
        end else if (create_vld) begin
          life_nxt = st_alloc;
        end
      end
      st_alloc: begin
        if (sys.flush) begin
          life_nxt = st_dealloc;
        end else if (cmd.release_vld && wb_masked) begin
          life_nxt = st_dealloc;
        end else if (cmd.release_vld) begin
          life_nxt = st_release;
        end else if (retire_vld) begin
          life_nxt = st_retire;
        end
      end
      st_retire: begin
        if (cmd.release_vld && wb_masked) begin
          life_nxt = st_dealloc;
        end else if (cmd.release_vld) begin
          life_nxt = st_release;
        end
      end
      st_release: begin
        if (wb_masked) begin
          life_nxt = st_dealloc;
        end
      end
      default: life_nxt = st_dealloc;
    endcase
  end

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      life_state <= st_dealloc;
    end else if (sys.sync_reset) begin
      life_state <= life_reset;
    end else begin
      life_state <= life_nxt;
    end
  end

  // ====================
  // Write back
  // ====================

  assign wb_reset = sys.reset_mapped ? wb_done : wb_idle;

  always_comb begin
    wb_nxt = wb_state;
    case (wb_state)
      wb_idle: if (cmd.wb_vld) wb_nxt = wb_done;
      wb_done: if (life_state == st_dealloc) wb_nxt = wb_idle;
      default: wb_nxt = wb_idle;
    endcase
  end

  // New producer clears any stale write-back
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_state <= wb_idle;
    end else if (sys.async_flush) begin
      wb_state <= wb_done;
    end else if (sys.sync_reset) begin
      wb_state <= wb_reset;
    end else if (create_vld) begin
      wb_state <= wb_idle;
    end else begin
      wb_state <= wb_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== source/vreg_retire_match.sv ====
// IID compare runs one or more cycles ahead of the commit
// A match bit only updates while its preview slot is valid
`default_nettype none
`timescale 1ns/1ps

module vreg_retire_match #(
  parameter int ret_slots = pst_cfg_pkg::ret_slots_default
) (
  input  wire logic                                        sm_clk,
  input  wire logic                                        cpurst_b,
  input  pst_types_pkg::retire_preview_t [ret_slots-1:0]   ret_preview,
  input  wire logic [ret_slots-1:0]                        ret_commit,
  input  wire logic [pst_cfg_pkg::iid_w-1:0]               entry_iid,
  input  wire logic                                        in_alloc,
  input  pst_types_pkg::sys_event_t                        sys,
  output logic                                             retire_vld
);

  logic [ret_slots-1:0] match_nxt;
  logic [ret_slots-1:0] match_q;

  // ====================
  // Early IID compare
  // ====================

  // Only an allocated entry can be retired
  always_comb begin
    for (int s = 0; s < ret_slots; s++) begin
      match_nxt[s] = in_alloc && (ret_preview[s].iid == entry_iid);
    end
  end

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      match_q <= '0;
    end else if (sys.sync_reset) begin
      match_q <= '0;
    end else begin
      for (int s = 0; s < ret_slots; s++) begin
        if (ret_preview[s].vld) begin
          match_q[s] <= match_nxt[s];
        end
      end
    end
  end

  // ====================
  // Retire strobe
  // ====================

  // Commit of any slot whose earlier preview matched
  assign retire_vld = |(match_q & ret_commit);

endmodule

`default_nettype wire

// ==== source/vreg_create_capture.sv ====
// create_sel must be one-hot or zero; more than one bit ORs the slots together
// sync_reset takes priority over a create in the same cycle
`default_nettype none
`timescale 1ns/1ps

module vreg_create_capture #(
  parameter int dis_slots = pst_cfg_pkg::dis_slots_default
) (
  input  wire logic                                       sm_clk,
  input  wire logic                                       cpurst_b,
  input  pst_types_pkg::entry_info_t [dis_slots-1:0]      dis_inst,
  input  wire logic [dis_slots-1:0]                       create_sel,
  input  pst_types_pkg::sys_event_t                       sys,
  input  wire logic [pst_cfg_pkg::dstv_w-1:0]             reset_dstv_reg,
  output logic                                            create_vld,
  output pst_types_pkg::entry_info_t                      info
);

  import pst_types_pkg::*;

  entry_info_t create_info;
  entry_info_t reset_info;

  // ====================
  // Create select
  // ====================

  assign create_vld = |create_sel;

  // One-hot mux over the dispatch slots
  always_comb begin
    create_info = '0;
    for (int i = 0; i < dis_slots; i++) begin
      if (create_sel[i]) begin
        create_info = entry_info_t'(create_info | dis_inst[i]);
      end
    end
  end

  // Sync reset maps the entry to reset_dstv_reg with no producer
  always_comb begin
    reset_info          = '0;
    reset_info.dstv_reg = reset_dstv_reg;
  end

  // ====================
  // Information register
  // ====================

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      info <= '0;
    end else if (sys.sync_reset) begin
      info <= reset_info;
    end else if (create_vld) begin
      info <= create_info;
    end
  end

endmodule

`default_nettype wire

// ==== source/pst_types_pkg.sv ====
// State encodings and grouped signals of one status entry
// Field widths follow pst_cfg_pkg
`default_nettype none

package pst_types_pkg;

  // ====================
  // State machines
  // ====================

  // Lifecycle, one-hot
  typedef enum logic [4:0] {
    st_dealloc  = 5'b00001,
    st_wf_alloc = 5'b00010,
    st_alloc    = 5'b00100,
    st_retire   = 5'b01000,
    st_release  = 5'b10000
  } lifecycle_e;

  // Result written back or not
  typedef enum logic {
    wb_idle = 1'b0,
    wb_done = 1'b1
  } wb_e;

  // ====================
  // Grouped signals
  // ====================

  // Creating instruction, one per dispatch slot
  typedef struct packed {
    logic [pst_cfg_pkg::iid_w-1:0]  iid;
    logic [pst_cfg_pkg::dstv_w-1:0] dstv_reg;
    logic [pst_cfg_pkg::vreg_w-1:0] rel_vreg;
  } entry_info_t;

  // Early retire candidate, one per retire slot
  typedef struct packed {
    logic                          vld;
    logic [pst_cfg_pkg::iid_w-1:0] iid;
  } retire_preview_t;

  typedef struct packed {
    logic flush;
    logic async_flush;
    logic sync_reset;
    logic reset_mapped;
  } sys_event_t;

  // Per-entry commands from the allocator
  typedef struct packed {
    logic dealloc_vld;
    logic dealloc_mask;
    logic release_vld;
    logic wb_vld;
  } entry_cmd_t;

  typedef struct packed {
    logic is_dealloc;
    logic alloc_or_release;
    logic retired_released_wb;
  } entry_status_t;

endpackage

`default_nettype wire

// ==== source/pst_cfg_pkg.sv ====
// Widths and slot counts for one vector physical register status entry
// Slot counts here are only defaults; the top level parameters win
`default_nettype none

package pst_cfg_pkg;

  // ====================
  // Field widths
  // ====================

  // Instruction ID carried by dispatch and retire
  localparam int iid_w  = 7;

  // Physical vreg index, selects one of num_vreg bits
  localparam int vreg_w = 6;

  // Architectural vector register index
  localparam int dstv_w = 5;

  // ====================
  // Vector sizes
  // ====================

  localparam int num_vreg = 64;
  localparam int num_areg = 32;

  // ====================
  // Slot counts
  // ====================

  localparam int dis_slots_default = 4;
  localparam int ret_slots_default = 3;

endpackage

`default_nettype wire
